// ==== verilog/arcade_params.svh ====
// Widths, divider counts, game codes, hardware-variant codes and dial period
`ifndef ARCADE_PARAMS_SVH
`define ARCADE_PARAMS_SVH

// ==========================================================
// Bus and sample widths
// ==========================================================
`define GAME_ID_W       7
`define DL_ADDR_W       25   // Host byte address
`define ROM_WADDR_W     22   // External ROM word address
`define AUDIO_W         10
`define DIAL_W          5    // Direction bit plus 4-bit position

// ==========================================================
// Timing
// ==========================================================
`define CE_1P79_DIV     14
`define DIAL_PERIOD     16   // Cycles per dial step with a button held

// Game codes as sent by the host
`define GAME_SCRAMBLE   0
`define GAME_AMIDAR     1
`define GAME_FROGGER    2
`define GAME_SCOBRA     3
`define GAME_MOONWAR    6

// Hardware variants of the game core
`define HWSEL_SCRAMBLE  0
`define HWSEL_FROGGER   1
`define HWSEL_SCOBRA    2

`endif

// ==== verilog/arcade_pkg.sv ====
// Package arcade_pkg with the shared vector types and the loader state enum
`include "arcade_params.svh"

package arcade_pkg;

	// ==========================================================
	// Host side
	// ==========================================================
	typedef logic [`GAME_ID_W-1:0] game_id_t;
	typedef logic [`DL_ADDR_W-1:0] dl_addr_t;

	// External ROM write port
	typedef logic [`ROM_WADDR_W-1:0] rom_waddr_t;
	typedef logic [15:0] rom_word_t;    // Two byte lanes

	// ==========================================================
	// Game core side
	// ==========================================================
	typedef logic [3:0] hwsel_t;
	typedef logic [7:0] port_byte_t;    // Active low

	typedef logic [`AUDIO_W-1:0] audio_t;

	// Moon War dial, top bit is the last direction
	typedef logic [`DIAL_W-1:0] dial_t;

	// Loader progress
	typedef enum logic [1:0]
	{
		LOAD_BOOT,    // Nothing loaded yet
		LOAD_BUSY,    // Download running
		LOAD_READY    // Complete image in ROM
	} load_state_t;

endpackage

// ==== verilog/clock_enables.sv ====
// Module clock_enables, the 12, 6 (both phases) and 1.79 clock-enable divider
`timescale 1ns/1ns
`include "arcade_params.svh"

module clock_enables
(
	input  logic clk_sys,
	input  logic rst_n_i,
	output logic ce_12_o,     // CPU and video pixel rate
	output logic ce_6p_o,
	output logic ce_6n_o,
	output logic ce_1p79_o    // Sound CPU
);

	localparam logic [3:0] DIV179_LOAD = 4'(`CE_1P79_DIV - 1);

	logic [1:0] phase;
	logic [3:0] div179;

	always_ff @(posedge clk_sys)
	begin
		if (!rst_n_i)
		begin
			phase  <= 2'd0;
			div179 <= DIV179_LOAD;
		end
		else
		begin
			phase <= phase + 2'd1;

			if (div179 == 4'd0)
				div179 <= DIV179_LOAD;    // Wrap, one pulse per period
			else
				div179 <= div179 - 4'd1;
		end
	end

	// Phase 0 during reset keeps every enable low
	assign ce_12_o = phase[0];
	assign ce_6p_o = (phase == 2'd1);
	assign ce_6n_o = (phase == 2'd3);     // Opposite half of the 6 MHz cycle

	assign ce_1p79_o = (div179 == 4'd0);

endmodule

// ==== verilog/rom_loader.sv ====
// Module rom_loader, the download to ROM word-write bridge, load tracking and core reset
`timescale 1ns/1ns
`include "arcade_params.svh"

module rom_loader
(
	input  logic                   clk_sys,
	input  logic                   rst_n_i,
	input  logic                   host_reset_i,     // Reset strobe from the host menu
	input  logic                   button_reset_i,   // Front panel
	input  logic                   dl_active_i,
	input  logic                   dl_wr_i,
	input  arcade_pkg::dl_addr_t   dl_addr_i,
	input  logic [7:0]             dl_data_i,
	output logic                   rom_req_o,        // Toggles once per word write
	output arcade_pkg::rom_waddr_t rom_waddr_o,
	output logic [1:0]             rom_ds_o,         // Byte lane strobes
	output arcade_pkg::rom_word_t  rom_wdata_o,
	output logic                   rom_we_o,
	output logic                   core_reset_o
);

	arcade_pkg::load_state_t state;

	logic dl_wr_q;
	logic wr_edge;

	// Rising edge of the host write strobe during a download
	assign wr_edge = dl_active_i & dl_wr_i & ~dl_wr_q;

	// ==========================================================
	// Write request path
	// ==========================================================
	always_ff @(posedge clk_sys)
	begin
		if (!rst_n_i)
		begin
			dl_wr_q   <= 1'b0;
			rom_req_o <= 1'b0;
			rom_we_o  <= 1'b0;
		end
		else
		begin
			dl_wr_q  <= dl_wr_i;
			rom_we_o <= dl_active_i;
			if (wr_edge)
				rom_req_o <= ~rom_req_o;    // Memory acts on each change
		end
	end

	always_ff @(posedge clk_sys)
	begin
		if (wr_edge)
		begin
			rom_waddr_o <= dl_addr_i[`ROM_WADDR_W:1];
			rom_ds_o    <= {dl_addr_i[0], ~dl_addr_i[0]};   // Odd byte to upper lane
			rom_wdata_o <= {2{dl_data_i}};
		end
	end

	// ==========================================================
	// Load state and core reset
	// ==========================================================
	always_ff @(posedge clk_sys)
	begin
		if (!rst_n_i)
			state <= arcade_pkg::LOAD_BOOT;
		else
		begin
			case (state)
				arcade_pkg::LOAD_BOOT,
				arcade_pkg::LOAD_READY:
					if (dl_active_i)
						state <= arcade_pkg::LOAD_BUSY;    // New image coming
				arcade_pkg::LOAD_BUSY:
					if (!dl_active_i)
						state <= arcade_pkg::LOAD_READY;
				default:
					state <= arcade_pkg::LOAD_BOOT;
			endcase
		end
	end

	// Download level included so reset rises together with LOAD_BUSY
	always_ff @(posedge clk_sys)
	begin
		if (!rst_n_i)
			core_reset_o <= 1'b1;
		else
			core_reset_o <= host_reset_i | button_reset_i | dl_active_i |
				(state != arcade_pkg::LOAD_READY);
	end

endmodule

// ==== verilog/dial_encoder.sv ====
// Module dial_encoder, the Moon War rotary dial position and direction encoder
`timescale 1ns/1ns
`include "arcade_params.svh"

module dial_encoder
(
	input  logic              clk_sys,
	input  logic              rst_n_i,
	input  logic              turn_left_i,
	input  logic              turn_right_i,
	output arcade_pkg::dial_t dial_o
);

	localparam int PRE_W = $clog2(`DIAL_PERIOD);
	localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(`DIAL_PERIOD - 1);

	logic [PRE_W-1:0] pre_cnt;
	logic [3:0]       position;
	logic             dir_right;
	logic             one_held;
	logic             step;

	// Both buttons together cancel out
	assign one_held = turn_left_i ^ turn_right_i;
	assign step     = one_held && (pre_cnt == PRE_LAST);

	always_ff @(posedge clk_sys)
	begin
		if (!rst_n_i)
		begin
			pre_cnt   <= '0;
			position  <= 4'd0;
			dir_right <= 1'b0;
		end
		else
		begin
			if (!one_held || step)
				pre_cnt <= '0;              // Restart period
			else
				pre_cnt <= pre_cnt + 1'b1;

			if (step)
			begin
				dir_right <= turn_right_i;
				position  <= turn_right_i ? position + 4'd1 : position - 4'd1;
			end
		end
	end

	assign dial_o = {dir_right, position};

endmodule

// ==== verilog/input_mapper.sv ====
// Module input_mapper, per-game mapping of controls and DIPs to port bytes and hwsel
`timescale 1ns/1ns
`include "arcade_params.svh"

module input_mapper
(
	input  arcade_pkg::game_id_t   game_id_i,
	input  logic                   coin1_i,
	input  logic                   coin2_i,
	input  logic                   start1_i,
	input  logic                   start2_i,
	input  logic [3:0]             p1_dir_i,         // Up, down, left, right
	input  logic [3:0]             p2_dir_i,
	input  logic [1:0]             p1_fire_i,
	input  logic [1:0]             p2_fire_i,
	input  logic [1:0]             dip_lives_i,
	input  logic                   dip_continue_i,
	input  arcade_pkg::dial_t      dial_i,
	output arcade_pkg::hwsel_t     hwsel_o,
	output arcade_pkg::port_byte_t port_a_o,
	output arcade_pkg::port_byte_t port_b_o,
	output arcade_pkg::port_byte_t port_c_o
);

	localparam arcade_pkg::game_id_t ID_SCRAMBLE = `GAME_SCRAMBLE;
	localparam arcade_pkg::game_id_t ID_AMIDAR   = `GAME_AMIDAR;
	localparam arcade_pkg::game_id_t ID_FROGGER  = `GAME_FROGGER;
	localparam arcade_pkg::game_id_t ID_SCOBRA   = `GAME_SCOBRA;
	localparam arcade_pkg::game_id_t ID_MOONWAR  = `GAME_MOONWAR;

	localparam arcade_pkg::hwsel_t HW_SCRAMBLE = `HWSEL_SCRAMBLE;
	localparam arcade_pkg::hwsel_t HW_FROGGER  = `HWSEL_FROGGER;
	localparam arcade_pkg::hwsel_t HW_SCOBRA   = `HWSEL_SCOBRA;

	logic p1_up, p1_down, p1_left, p1_right;
	logic p2_up, p2_down, p2_left, p2_right;

	assign {p1_up, p1_down, p1_left, p1_right} = p1_dir_i;
	assign {p2_up, p2_down, p2_left, p2_right} = p2_dir_i;

	// ==========================================================
	// Port assembly
	// ==========================================================
	always_comb
	begin
		// Base layout shared by the Scramble family
		port_a_o = ~{coin1_i, coin2_i, p1_left, p1_right,
			p1_fire_i[0], 1'b0, p1_fire_i[1], p2_up};   // Bit 2 is service
		port_b_o = ~{start1_i, start2_i, p2_left, p2_right,
			p2_fire_i[0], p2_fire_i[1], ~dip_lives_i};
		port_c_o = ~{1'b1, p1_down, 1'b1, p1_up,
			1'b1, 2'b11, p2_down};                       // Cabinet and coinage fixed
		hwsel_o  = HW_SCRAMBLE;

		case (game_id_i)
			ID_SCRAMBLE:
				hwsel_o = HW_SCRAMBLE;
			ID_AMIDAR:
			begin
				hwsel_o       = HW_SCRAMBLE;
				port_b_o[1:0] = ~dip_lives_i;   // Lives switch sense is reversed
			end
			ID_FROGGER:
				hwsel_o = HW_FROGGER;
			ID_SCOBRA:
			begin
				hwsel_o     = HW_SCOBRA;
				port_b_o[0] = dip_continue_i;
				port_b_o[1] = dip_lives_i[0];
			end
			ID_MOONWAR:
			begin
				hwsel_o  = HW_SCOBRA;
				// Dial replaces the joystick on port A
				port_a_o = ~{coin1_i, coin2_i, 1'b0, dial_i};
				port_b_o = ~{p1_fire_i[0], p1_fire_i[1], p2_fire_i[0], p2_fire_i[1],
					start2_i, start1_i, ~dip_lives_i};
				port_c_o = 8'hFE;
			end
			default:
				hwsel_o = HW_SCRAMBLE;      // Unknown code runs as Scramble
		endcase
	end

endmodule

// ==== verilog/audio_dac.sv ====
// Module audio_dac, the first-order delta-sigma one-bit audio output
`timescale 1ns/1ns
`include "arcade_params.svh"

module audio_dac
(
	input  logic               clk_sys,
	input  logic               rst_n_i,
	input  arcade_pkg::audio_t audio_i,
	output logic               audio_o     // Pulse density output
);

	// Top bit holds the carry of the last addition
	logic [`AUDIO_W:0] acc;

	always_ff @(posedge clk_sys)
	begin
		if (!rst_n_i)
			acc <= '0;
		else
			acc <= {1'b0, acc[`AUDIO_W-1:0]} + {1'b0, audio_i};
	end

	// Ones density follows audio_i over 2^AUDIO_W cycles
	assign audio_o = acc[`AUDIO_W];

endmodule

// ==== verilog/arcade_glue_top.sv ====
// Module arcade_glue_top, which connects loader, enables, dial, input mapping and DAC
`timescale 1ns/1ns
`include "arcade_params.svh"

module arcade_glue_top
(
	input  logic                   clk_sys,
	input  logic                   rst_n_i,
	// Host and ROM
	input  logic                   host_reset_i,
	input  logic                   button_reset_i,
	input  logic                   dl_active_i,
	input  logic                   dl_wr_i,
	input  arcade_pkg::dl_addr_t   dl_addr_i,
	input  logic [7:0]             dl_data_i,
	output logic                   rom_req_o,
	output arcade_pkg::rom_waddr_t rom_waddr_o,
	output logic [1:0]             rom_ds_o,
	output arcade_pkg::rom_word_t  rom_wdata_o,
	output logic                   rom_we_o,
	output logic                   core_reset_o,
	// Game core pacing
	output logic                   ce_12_o,
	output logic                   ce_6p_o,
	output logic                   ce_6n_o,
	output logic                   ce_1p79_o,
	// Controls
	input  arcade_pkg::game_id_t   game_id_i,
	input  logic                   coin1_i,
	input  logic                   coin2_i,
	input  logic                   start1_i,
	input  logic                   start2_i,
	input  logic [3:0]             p1_dir_i,
	input  logic [3:0]             p2_dir_i,
	input  logic [1:0]             p1_fire_i,
	input  logic [1:0]             p2_fire_i,
	input  logic [1:0]             dip_lives_i,
	input  logic                   dip_continue_i,
	output arcade_pkg::hwsel_t     hwsel_o,
	output arcade_pkg::port_byte_t port_a_o,
	output arcade_pkg::port_byte_t port_b_o,
	output arcade_pkg::port_byte_t port_c_o,
	// Sound
	input  arcade_pkg::audio_t     audio_i,
	output logic                   audio_o
);

	arcade_pkg::dial_t dial_code;
	logic turn_left, turn_right;

	// ==========================================================
	// Input side
	// ==========================================================
	assign turn_left  = p1_dir_i[1] | p1_dir_i[3];   // Left or up
	assign turn_right = p1_dir_i[0] | p1_dir_i[2];   // Right or down

	rom_loader u_rom_loader (.clk_sys(clk_sys), .rst_n_i(rst_n_i),
		.host_reset_i(host_reset_i), .button_reset_i(button_reset_i),
		.dl_active_i(dl_active_i), .dl_wr_i(dl_wr_i), .dl_addr_i(dl_addr_i),
		.dl_data_i(dl_data_i), .rom_req_o(rom_req_o), .rom_waddr_o(rom_waddr_o),
		.rom_ds_o(rom_ds_o), .rom_wdata_o(rom_wdata_o), .rom_we_o(rom_we_o),
		.core_reset_o(core_reset_o));

	dial_encoder u_dial_encoder (.clk_sys(clk_sys), .rst_n_i(rst_n_i),
		.turn_left_i(turn_left), .turn_right_i(turn_right), .dial_o(dial_code));

	// ==========================================================
	// Processing and output side
	// ==========================================================
	input_mapper u_input_mapper (.game_id_i(game_id_i), .coin1_i(coin1_i),
		.coin2_i(coin2_i), .start1_i(start1_i), .start2_i(start2_i),
		.p1_dir_i(p1_dir_i), .p2_dir_i(p2_dir_i), .p1_fire_i(p1_fire_i),
		.p2_fire_i(p2_fire_i), .dip_lives_i(dip_lives_i),
		.dip_continue_i(dip_continue_i), .dial_i(dial_code), .hwsel_o(hwsel_o),
		.port_a_o(port_a_o), .port_b_o(port_b_o), .port_c_o(port_c_o));

	clock_enables u_clock_enables (.clk_sys(clk_sys), .rst_n_i(rst_n_i),
		.ce_12_o(ce_12_o), .ce_6p_o(ce_6p_o), .ce_6n_o(ce_6n_o),
		.ce_1p79_o(ce_1p79_o));

	audio_dac u_audio_dac (.clk_sys(clk_sys), .rst_n_i(rst_n_i),
		.audio_i(audio_i), .audio_o(audio_o));

endmodule

// ==== bench/arcade_glue_props.sv ====
// Module arcade_glue_props with loader and clock-enable assertions, and the bind statements
`timescale 1ns/1ns

module arcade_glue_props
(
	input logic                    clk_sys,
	input logic                    rst_n_i,
	input logic                    rom_req_i,
	input logic                    rom_we_i,
	input logic                    core_reset_i,
	input arcade_pkg::load_state_t state_i,
	input logic                    ce_6p_i,
	input logic                    ce_6n_i
);

	// Memory sees request changes only while a download writes
	req_during_write: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		(rom_req_i != $past(rom_req_i)) |-> rom_we_i)
		else $error("rom_req_o changed while rom_we_o was low");

	// Core stays in reset until a full image is loaded
	reset_until_ready: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		(state_i != arcade_pkg::LOAD_READY) |-> core_reset_i)
		else $error("core_reset_o low while the loader is not ready");

	six_phases_apart: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		!(ce_6p_i && ce_6n_i))
		else $error("ce_6p_o and ce_6n_o high in the same cycle");

endmodule

// Ports absent from the bound module are tied to idle values
bind rom_loader arcade_glue_props u_loader_props (.clk_sys(clk_sys), .rst_n_i(rst_n_i),
	.rom_req_i(rom_req_o), .rom_we_i(rom_we_o), .core_reset_i(core_reset_o),
	.state_i(state), .ce_6p_i(1'b0), .ce_6n_i(1'b0));

bind clock_enables arcade_glue_props u_ce_props (.clk_sys(clk_sys), .rst_n_i(rst_n_i),
	.rom_req_i(1'b0), .rom_we_i(1'b1), .core_reset_i(1'b1),
	.state_i(arcade_pkg::LOAD_READY), .ce_6p_i(ce_6p_o), .ce_6n_i(ce_6n_o));

// ==== bench/arcade_glue_tb.sv ====
// Module arcade_glue_tb, the testbench of arcade_glue_top with stimulus table and checks
`timescale 1ns/1ns
`include "arcade_params.svh"

module arcade_glue_tb;

	localparam int WAIT_LIMIT = 8;
	localparam int N_MAP      = 7;

	typedef struct packed
	{
		arcade_pkg::game_id_t   game;
		logic [3:0]             p1_dir;
		logic [3:0]             p2_dir;
		logic [1:0]             p1_fire;
		logic [1:0]             p2_fire;
		logic [3:0]             coin_start;    // Coin1, coin2, start1, start2
		logic [1:0]             lives;
		logic                   cont;
		arcade_pkg::port_byte_t exp_a;
		arcade_pkg::port_byte_t exp_b;
		arcade_pkg::port_byte_t exp_c;
		arcade_pkg::hwsel_t     exp_hw;
	} map_entry_t;

	logic clk_sys, rst_n_i, host_reset_i, button_reset_i;
	logic dl_active_i, dl_wr_i, rom_req_o, rom_we_o, core_reset_o;
	arcade_pkg::dl_addr_t   dl_addr_i;
	logic [7:0]             dl_data_i;
	arcade_pkg::rom_waddr_t rom_waddr_o;
	logic [1:0]             rom_ds_o;
	arcade_pkg::rom_word_t  rom_wdata_o;
	logic ce_12_o, ce_6p_o, ce_6n_o, ce_1p79_o;
	arcade_pkg::game_id_t   game_id_i;
	logic coin1_i, coin2_i, start1_i, start2_i, dip_continue_i, audio_o;
	logic [3:0]             p1_dir_i, p2_dir_i;
	logic [1:0]             p1_fire_i, p2_fire_i, dip_lives_i;
	arcade_pkg::hwsel_t     hwsel_o;
	arcade_pkg::port_byte_t port_a_o, port_b_o, port_c_o;
	arcade_pkg::audio_t     audio_i;

	map_entry_t  map_tab [N_MAP];
	int          errors, tests, test_err0;
	logic [31:0] lcg_state;

	arcade_glue_top u_dut (.*);

	initial
	begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// ==========================================================
	// Compare tasks
	// ==========================================================
	task automatic report_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("** Error: %s: expected %0h, actual %0h", name, exp, act);
		errors++;
	endtask

	task automatic check_port(input string name, input arcade_pkg::port_byte_t exp,
		input arcade_pkg::port_byte_t act);
		if (act !== exp)
			report_value(name, 32'(exp), 32'(act));
	endtask

	task automatic check_hwsel(input string name, input arcade_pkg::hwsel_t exp,
		input arcade_pkg::hwsel_t act);
		if (act !== exp)
			report_value(name, 32'(exp), 32'(act));
	endtask

	task automatic check_waddr(input string name, input arcade_pkg::rom_waddr_t exp,
		input arcade_pkg::rom_waddr_t act);
		if (act !== exp)
			report_value(name, 32'(exp), 32'(act));
	endtask

	task automatic check_word(input string name, input arcade_pkg::rom_word_t exp,
		input arcade_pkg::rom_word_t act);
		if (act !== exp)
			report_value(name, 32'(exp), 32'(act));
	endtask

	task automatic check_count(input string name, input integer exp, input integer act,
		input integer tol);
		if (act < exp - tol || act > exp + tol)
			report_value(name, exp, act);
	endtask

	task automatic tick(input int n);
		repeat (n) @(negedge clk_sys);    // Inputs change and outputs are read here
	endtask

	task automatic apply_reset();
		rst_n_i = 1'b0;
		tick(3);
		rst_n_i = 1'b1;
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("%s: %s", name, (errors == test_err0) ? "ok" : "errors found");
		test_err0 = errors;
	endtask

	// Hold the dial buttons until port A shows the code, one period of slack
	task automatic wait_dial(input string name, input arcade_pkg::dial_t exp_dial,
		input int periods);
		int cycles;
		arcade_pkg::port_byte_t exp_a;
		cycles = 0;
		exp_a  = ~{3'b000, exp_dial};
		while (port_a_o !== exp_a && cycles < (periods + 1) * `DIAL_PERIOD)
		begin
			tick(1);
			cycles++;
		end
		if (port_a_o !== exp_a)
		begin
			$display("%s: dial code not reached within %0d cycles", name, cycles);
			errors++;
		end
		else
			check_count({name, "_cycles"}, periods * `DIAL_PERIOD, cycles, `DIAL_PERIOD);
	endtask

	initial
	begin
		int count_12, count_6p, count_6n, count_179, cycles, ones;
		logic [1:0] last_6;
		arcade_pkg::dl_addr_t addr;
		logic [7:0] data;
		logic req_prev;
		int samples [3];

		{rst_n_i, host_reset_i, button_reset_i, dl_active_i, dl_wr_i} = 5'b00000;
		{coin1_i, coin2_i, start1_i, start2_i, dip_continue_i} = 5'b00000;
		{p1_dir_i, p2_dir_i, p1_fire_i, p2_fire_i, dip_lives_i} = '0;
		dl_addr_i = '0;
		dl_data_i = 8'h00;
		game_id_i = '0;
		audio_i   = '0;
		errors    = 0;
		tests     = 0;
		test_err0 = 0;
		lcg_state = 32'd95302;
		samples   = '{0, 256, 1023};

		// Game code, controls and DIPs, then expected A, B, C and hwsel
		map_tab[0] = '{`GAME_SCRAMBLE, 4'b0000, 4'b0000, 2'b00, 2'b00, 4'b0000, 2'b00, 1'b0,
			8'hFF, 8'hFC, 8'h51, `HWSEL_SCRAMBLE};
		map_tab[1] = '{`GAME_AMIDAR, 4'b0001, 4'b0000, 2'b01, 2'b00, 4'b1000, 2'b10, 1'b0,
			8'h67, 8'hFD, 8'h51, `HWSEL_SCRAMBLE};
		map_tab[2] = '{`GAME_FROGGER, 4'b0100, 4'b1010, 2'b00, 2'b10, 4'b0010, 2'b01, 1'b0,
			8'hFE, 8'h59, 8'h11, `HWSEL_FROGGER};
		map_tab[3] = '{`GAME_SCOBRA, 4'b0000, 4'b0101, 2'b11, 2'b00, 4'b0101, 2'b10, 1'b1,
			8'hB5, 8'hAD, 8'h50, `HWSEL_SCOBRA};
		map_tab[4] = '{`GAME_MOONWAR, 4'b0000, 4'b1111, 2'b10, 2'b01, 4'b1010, 2'b00, 1'b0,
			8'h7F, 8'h98, 8'hFE, `HWSEL_SCOBRA};
		map_tab[5] = '{7'd5, 4'b1010, 4'b0000, 2'b00, 2'b00, 4'b1100, 2'b11, 1'b0,
			8'h1F, 8'hFF, 8'h41, `HWSEL_SCRAMBLE};    // Unknown code
		map_tab[6] = '{`GAME_SCRAMBLE, 4'b0000, 4'b1111, 2'b00, 2'b11, 4'b0001, 2'b01, 1'b0,
			8'hFE, 8'h81, 8'h50, `HWSEL_SCRAMBLE};

		apply_reset();
		check_count("reset_enables", 0, int'({ce_12_o, ce_6p_o, ce_6n_o, ce_1p79_o}), 0);
		check_count("reset_rom_req", 0, int'(rom_req_o), 0);
		check_count("reset_core_reset", 1, int'(core_reset_o), 0);
		end_test("reset_state");

		// ==========================================================
		// Clock enables over four 1.79 periods
		// ==========================================================
		count_12  = 0;
		count_6p  = 0;
		count_6n  = 0;
		count_179 = 0;
		last_6    = 2'b00;
		repeat (4 * `CE_1P79_DIV)
		begin
			tick(1);
			count_12  += int'(ce_12_o);
			count_6p  += int'(ce_6p_o);
			count_6n  += int'(ce_6n_o);
			count_179 += int'(ce_1p79_o);
			if ((ce_6p_o || ce_6n_o) && {ce_6p_o, ce_6n_o} == last_6)
			begin
				$display("clock_enables: ce_6p and ce_6n did not alternate at %0t", $time);
				errors++;
			end
			if (ce_6p_o || ce_6n_o)
				last_6 = {ce_6p_o, ce_6n_o};
		end
		check_count("ce_12_count", 28, count_12, 0);
		check_count("ce_6p_count", 14, count_6p, 0);
		check_count("ce_6n_count", 14, count_6n, 0);
		check_count("ce_1p79_count", 4, count_179, 0);
		end_test("clock_enables");

		// ==========================================================
		// ROM download
		// ==========================================================
		dl_active_i = 1'b1;
		for (int i = 0; i < 8; i++)
		begin
			addr      = arcade_pkg::dl_addr_t'(lcg_next() >> 7);
			data      = 8'(lcg_next() >> 16);
			req_prev  = rom_req_o;
			dl_addr_i = addr;
			dl_data_i = data;
			dl_wr_i   = 1'b1;
			tick(1);
			dl_wr_i = 1'b0;
			check_count("dl_req_toggle", req_prev ? 0 : 1, int'(rom_req_o), 0);
			check_waddr("dl_waddr", arcade_pkg::rom_waddr_t'(addr >> 1), rom_waddr_o);
			check_count("dl_lanes", addr[0] ? 2 : 1, int'(rom_ds_o), 0);
			check_word("dl_wdata", {data, data}, rom_wdata_o);
			check_count("dl_we", 1, int'(rom_we_o), 0);
			check_count("dl_core_reset", 1, int'(core_reset_o), 0);
			tick(1);    // Strobe low for one cycle
		end
		dl_active_i = 1'b0;
		cycles = 0;
		do
		begin
			tick(1);
			cycles++;
		end
		while (core_reset_o && cycles < WAIT_LIMIT);
		if (core_reset_o)
		begin
			$display("rom_download: core reset still high %0d cycles after the end", cycles);
			errors++;
		end
		else
			check_count("dl_reset_release", 2, cycles, 0);
		check_count("dl_we_end", 0, int'(rom_we_o), 0);
		end_test("rom_download");

		for (int i = 0; i < N_MAP; i++)
		begin
			game_id_i      = map_tab[i].game;
			p1_dir_i       = map_tab[i].p1_dir;
			p2_dir_i       = map_tab[i].p2_dir;
			p1_fire_i      = map_tab[i].p1_fire;
			p2_fire_i      = map_tab[i].p2_fire;
			dip_lives_i    = map_tab[i].lives;
			dip_continue_i = map_tab[i].cont;
			{coin1_i, coin2_i, start1_i, start2_i} = map_tab[i].coin_start;
			tick(1);
			check_port($sformatf("map%0d_port_a", i), map_tab[i].exp_a, port_a_o);
			check_port($sformatf("map%0d_port_b", i), map_tab[i].exp_b, port_b_o);
			check_port($sformatf("map%0d_port_c", i), map_tab[i].exp_c, port_c_o);
			check_hwsel($sformatf("map%0d_hwsel", i), map_tab[i].exp_hw, hwsel_o);
		end
		end_test("port_mapping");

		// ==========================================================
		// Moon War dial and audio
		// ==========================================================
		apply_reset();
		game_id_i = arcade_pkg::game_id_t'(`GAME_MOONWAR);
		{coin1_i, coin2_i} = 2'b00;
		p1_dir_i = 4'b0001;    // Right
		wait_dial("dial_right", {1'b1, 4'd4}, 4);
		p1_dir_i = 4'b0010;    // Left
		wait_dial("dial_left", {1'b0, 4'd14}, 6);
		p1_dir_i = 4'b0000;
		end_test("moonwar_dial");

		foreach (samples[k])
		begin
			audio_i = arcade_pkg::audio_t'(samples[k]);
			tick(1);    // First sum with the new sample
			ones = 0;
			repeat (1 << `AUDIO_W)
			begin
				tick(1);
				ones += int'(audio_o);
			end
			check_count($sformatf("audio_%0d", samples[k]), samples[k], ones, 1);
		end
		end_test("audio_dac");

		$display("Summary: %0d tests, %0d errors", tests, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/arcade_pkg.sv
verilog/clock_enables.sv
verilog/rom_loader.sv
verilog/dial_encoder.sv
verilog/input_mapper.sv
verilog/audio_dac.sv
verilog/arcade_glue_top.sv
bench/arcade_glue_props.sv
bench/arcade_glue_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and search the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module arcade_glue_tb \
	--Mdir obj_dir -o arcade_glue_sim > build.log 2>&1 \
	&& ./obj_dir/arcade_glue_sim > sim.log 2>&1 \
	|| { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "Test failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Test passed" sim.log || { echo "No result found in sim.log"; exit 1; }
echo "Simulation PASSED"
